// File: verilog/bmu_macros.svh
`ifndef BMU_MACROS_SVH
`define BMU_MACROS_SVH

// ------------------------------
// Datapath widths
// ------------------------------

`define BMU_XLEN 32
`define BMU_REG_ADDR_W 5
`define BMU_INSTR_W 32

// ------------------------------
// R-type instruction fields
// ------------------------------

`define BMU_FUNCT7_W 7
`define BMU_FUNCT3_W 3
`define BMU_MAJOR_W 5
`define BMU_LOW_W 2

// Width of the funct7 and rs2 fields taken together
`define BMU_IMM12_W 12

`endif

// File: verilog/bmu_decode_pkg.sv
`include "bmu_macros.svh"

package bmu_decode_pkg;

    // ------------------------------
    // Instruction view
    // ------------------------------

    // Bits 6 to 2 of the instruction word
    typedef enum logic [`BMU_MAJOR_W-1:0] {
        OP_IMM = 5'b00100,
        OP     = 5'b01100
    } rv_major_e;

    typedef struct packed {
        logic [`BMU_FUNCT7_W-1:0]   funct7;
        logic [`BMU_REG_ADDR_W-1:0] rs2;
        logic [`BMU_REG_ADDR_W-1:0] rs1;
        logic [`BMU_FUNCT3_W-1:0]   funct3;
        logic [`BMU_REG_ADDR_W-1:0] rd;
        rv_major_e                  major;
        logic [`BMU_LOW_W-1:0]      low_bits;
    } bmu_instr_t;

    // ------------------------------
    // Micro-op encoding
    // ------------------------------

    typedef enum logic [2:0] {
        NONE,
        LOGICOP,
        COUNT,
        EXTEND,
        ROTATE,
        BYTEOP,
        SHADD,
        COMPARE
    } bmu_op_type_e;

    // Immediate and register forms of an operation share one opcode
    typedef enum logic [4:0] {
        NOP = 5'd0,
        BSET,
        BCLR,
        BINV,
        BEXT,
        ROL,
        ROR,
        CLZ,
        CTZ,
        CPOP,
        SEXTB,
        SEXTH,
        ZEXTH,
        REV8,
        ORCB,
        SH1ADD,
        SH2ADD,
        SH3ADD,
        MIN,
        MINU,
        MAX,
        MAXU,
        ANDN,
        ORN,
        XNOR
    } bmu_opcode_e;

    typedef struct packed {
        bmu_op_type_e op_type;
        bmu_opcode_e  opcode;
    } bmu_uop_t;

    // Register fields are zero when the operation does not use them
    typedef struct packed {
        bmu_uop_t                   uop;
        logic [`BMU_REG_ADDR_W-1:0] rs1;
        logic [`BMU_REG_ADDR_W-1:0] rs2;
        logic [`BMU_REG_ADDR_W-1:0] rd;
        logic [`BMU_XLEN-1:0]       imm;
        logic                       imm_valid;
        logic                       illegal;
    } bmu_decoded_t;

endpackage

// File: verilog/bmu_imm_decoder.sv
`timescale 1ns/1ps

`include "bmu_macros.svh"

module bmu_imm_decoder
    import bmu_decode_pkg::*;
(
    input  bmu_instr_t   instr_i,
    output bmu_decoded_t dec_o,
    output logic         illegal_o
);

    // Upper twelve bits of REV8 and ORC.B are fixed encodings
    localparam logic [`BMU_IMM12_W-1:0] REV8_IMM = 12'b011010011000;
    localparam logic [`BMU_IMM12_W-1:0] ORCB_IMM = 12'b001010000111;

    bmu_uop_t uop;
    logic     use_imm;
    logic     illegal;

    logic [`BMU_IMM12_W-1:0] upper_bits;

    assign upper_bits = {instr_i.funct7, instr_i.rs2};

    // ------------------------------
    // Field decode
    // ------------------------------

    always_comb begin
        uop     = '{NONE, NOP};
        use_imm = 1'b0;
        illegal = 1'b0;

        case (instr_i.funct3)
            3'b001: begin
                case (instr_i.funct7)
                    7'b0010100: begin
                        uop     = '{LOGICOP, BSET};
                        use_imm = 1'b1;
                    end
                    7'b0100100: begin
                        uop     = '{LOGICOP, BCLR};
                        use_imm = 1'b1;
                    end
                    7'b0110100: begin
                        uop     = '{LOGICOP, BINV};
                        use_imm = 1'b1;
                    end
                    // Unary group, the rs2 field picks the operation
                    7'b0110000: begin
                        case (instr_i.rs2)
                            5'd0: uop = '{COUNT, CLZ};
                            5'd1: uop = '{COUNT, CTZ};
                            5'd2: uop = '{COUNT, CPOP};
                            5'd4: uop = '{EXTEND, SEXTB};
                            5'd5: uop = '{EXTEND, SEXTH};
                            default: illegal = 1'b1;
                        endcase
                    end
                    default: illegal = 1'b1;
                endcase
            end

            3'b101: begin
                if (upper_bits == REV8_IMM) begin
                    uop = '{BYTEOP, REV8};
                end else if (upper_bits == ORCB_IMM) begin
                    uop = '{BYTEOP, ORCB};
                end else begin
                    case (instr_i.funct7)
                        7'b0100100: begin
                            uop     = '{LOGICOP, BEXT};
                            use_imm = 1'b1;
                        end
                        7'b0110000: begin
                            uop     = '{ROTATE, ROR};
                            use_imm = 1'b1;
                        end
                        default: illegal = 1'b1;
                    endcase
                end
            end

            default: illegal = 1'b1;
        endcase
    end

    // ------------------------------
    // Packet
    // ------------------------------

    // Every OP-IMM form reads rs1, the shift amount sits in the rs2 field
    assign dec_o.uop       = uop;
    assign dec_o.rs1       = instr_i.rs1;
    assign dec_o.rs2       = '0;
    assign dec_o.rd        = instr_i.rd;
    assign dec_o.imm       = use_imm ?
                             {{(`BMU_XLEN-`BMU_REG_ADDR_W){1'b0}}, instr_i.rs2} : '0;
    assign dec_o.imm_valid = use_imm;
    assign dec_o.illegal   = illegal;

    assign illegal_o = illegal;

endmodule

// File: verilog/bmu_reg_decoder.sv
`timescale 1ns/1ps

module bmu_reg_decoder
    import bmu_decode_pkg::*;
(
    input  bmu_instr_t   instr_i,
    output bmu_decoded_t dec_o,
    output logic         illegal_o
);

    bmu_uop_t uop;
    logic     use_rs2;
    logic     illegal;

    // ------------------------------
    // Field decode
    // ------------------------------

    always_comb begin
        uop     = '{NONE, NOP};
        use_rs2 = 1'b1;
        illegal = 1'b0;

        case (instr_i.funct3)
            3'b001: begin
                case (instr_i.funct7)
                    7'b0010100: uop = '{LOGICOP, BSET};
                    7'b0100100: uop = '{LOGICOP, BCLR};
                    7'b0110100: uop = '{LOGICOP, BINV};
                    7'b0110000: uop = '{ROTATE, ROL};
                    default: illegal = 1'b1;
                endcase
            end

            3'b010: begin
                if (instr_i.funct7 == 7'b0010000) begin
                    uop = '{SHADD, SH1ADD};
                end else begin
                    illegal = 1'b1;
                end
            end

            3'b100: begin
                case (instr_i.funct7)
                    7'b0010000: uop = '{SHADD, SH2ADD};
                    7'b0000101: uop = '{COMPARE, MIN};
                    7'b0100000: uop = '{LOGICOP, XNOR};
                    // ZEXT.H is unary and keeps rs2 at zero
                    7'b0000100: begin
                        uop     = '{EXTEND, ZEXTH};
                        use_rs2 = 1'b0;
                        illegal = (instr_i.rs2 != '0);
                    end
                    default: illegal = 1'b1;
                endcase
            end

            3'b101: begin
                case (instr_i.funct7)
                    7'b0000101: uop = '{COMPARE, MINU};
                    7'b0100100: uop = '{LOGICOP, BEXT};
                    7'b0110000: uop = '{ROTATE, ROR};
                    default: illegal = 1'b1;
                endcase
            end

            3'b110: begin
                case (instr_i.funct7)
                    7'b0000101: uop = '{COMPARE, MAX};
                    7'b0010000: uop = '{SHADD, SH3ADD};
                    7'b0100000: uop = '{LOGICOP, ORN};
                    default: illegal = 1'b1;
                endcase
            end

            3'b111: begin
                case (instr_i.funct7)
                    7'b0100000: uop = '{LOGICOP, ANDN};
                    7'b0000101: uop = '{COMPARE, MAXU};
                    default: illegal = 1'b1;
                endcase
            end

            default: illegal = 1'b1;
        endcase
    end

    // ------------------------------
    // Packet
    // ------------------------------

    assign dec_o.uop       = uop;
    assign dec_o.rs1       = instr_i.rs1;
    assign dec_o.rs2       = use_rs2 ? instr_i.rs2 : '0;
    assign dec_o.rd        = instr_i.rd;
    // Register forms never carry an immediate
    assign dec_o.imm       = '0;
    assign dec_o.imm_valid = 1'b0;
    assign dec_o.illegal   = illegal;

    assign illegal_o = illegal;

endmodule

// File: verilog/bmu_decode_stage.sv
`timescale 1ns/1ps

module bmu_decode_stage
    import bmu_decode_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_i,

    input  logic         instr_valid_i,
    output logic         instr_ready_o,
    input  bmu_instr_t   instr_i,

    input  bmu_decoded_t imm_dec_i,
    input  bmu_decoded_t reg_dec_i,
    input  logic         imm_illegal_i,
    input  logic         reg_illegal_i,

    output logic         dec_valid_o,
    input  logic         dec_ready_i,
    output bmu_decoded_t dec_o
);

    bmu_decoded_t sel_dec;
    bmu_decoded_t next_dec;
    logic         sel_illegal;
    logic         illegal;

    bmu_decoded_t out_q;
    logic         out_valid_q;
    logic         accept;

    // ------------------------------
    // Decoder select and legality
    // ------------------------------

    always_comb begin
        case (instr_i.major)
            OP_IMM: begin
                sel_dec     = imm_dec_i;
                sel_illegal = imm_illegal_i;
            end
            OP: begin
                sel_dec     = reg_dec_i;
                sel_illegal = reg_illegal_i;
            end
            default: begin
                sel_dec     = '0;
                sel_illegal = 1'b1;
            end
        endcase
    end

    // Compressed encodings land here as well, through the low bits
    assign illegal = sel_illegal | (instr_i.low_bits != 2'b11);

    always_comb begin
        next_dec = '0;
        if (illegal) begin
            next_dec.illegal = 1'b1;
        end else begin
            next_dec         = sel_dec;
            next_dec.illegal = 1'b0;
        end
    end

    // ------------------------------
    // Output register
    // ------------------------------

    // A new item may enter while the current one leaves
    assign instr_ready_o = !out_valid_q || dec_ready_i;
    assign accept        = instr_valid_i && instr_ready_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            out_valid_q <= 1'b0;
        end else if (instr_ready_o) begin
            out_valid_q <= instr_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            out_q <= next_dec;
        end
    end

    assign dec_valid_o = out_valid_q;
    assign dec_o       = out_q;

endmodule

// File: verilog/bmu_decoder_top.sv
`timescale 1ns/1ps

module bmu_decoder_top
    import bmu_decode_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_i,

    input  logic         instr_valid_i,
    input  bmu_instr_t   instr_i,
    output logic         instr_ready_o,

    output logic         dec_valid_o,
    output bmu_decoded_t dec_o,
    input  logic         dec_ready_i
);

    bmu_decoded_t imm_dec;
    bmu_decoded_t reg_dec;
    logic         imm_illegal;
    logic         reg_illegal;

    // Both decoders see every word, the stage picks one by major opcode
    bmu_imm_decoder u_imm_decoder (
        .instr_i   (instr_i),
        .dec_o     (imm_dec),
        .illegal_o (imm_illegal)
    );

    bmu_reg_decoder u_reg_decoder (
        .instr_i   (instr_i),
        .dec_o     (reg_dec),
        .illegal_o (reg_illegal)
    );

    bmu_decode_stage u_decode_stage (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .instr_ready_o (instr_ready_o),
        .instr_i       (instr_i),
        .imm_dec_i     (imm_dec),
        .reg_dec_i     (reg_dec),
        .imm_illegal_i (imm_illegal),
        .reg_illegal_i (reg_illegal),
        .dec_valid_o   (dec_valid_o),
        .dec_ready_i   (dec_ready_i),
        .dec_o         (dec_o)
    );

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset drops on the edge that closes the last reset cycle
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

// File: testbench/tb_bmu_decoder.sv
`timescale 1ns/1ps

`include "bmu_macros.svh"

module tb_bmu_decoder
    import bmu_decode_pkg::*;
();

    // About four times the ~4200 transfers at a 70 percent ready rate
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int RANDOM_WORDS   = 4000;

    logic         clk;
    logic         rst;
    logic         instr_valid;
    bmu_instr_t   instr;
    logic         instr_ready;
    logic         dec_valid;
    bmu_decoded_t dec;
    logic         dec_ready;

    bmu_decoded_t            exp_q[$];
    logic [`BMU_INSTR_W-1:0] word_q[$];
    bmu_decoded_t            held_dec;
    logic                    holding     = 1'b0;
    logic                    reset_tail  = 1'b0;
    int                      cycle_count = 0;

    tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(10)) u_clock_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    bmu_decoder_top UUT (
        .clk_i         (clk),
        .rst_i         (rst),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .instr_ready_o (instr_ready),
        .dec_valid_o   (dec_valid),
        .dec_o         (dec),
        .dec_ready_i   (dec_ready)
    );

    // ------------------------------
    // Reference model
    // ------------------------------

    function automatic bmu_op_type_e class_of(input bmu_opcode_e opc);
        case (opc)
            BSET, BCLR, BINV, BEXT, ANDN, ORN, XNOR: return LOGICOP;
            CLZ, CTZ, CPOP: return COUNT;
            SEXTB, SEXTH, ZEXTH: return EXTEND;
            ROL, ROR: return ROTATE;
            REV8, ORCB: return BYTEOP;
            SH1ADD, SH2ADD, SH3ADD: return SHADD;
            MIN, MINU, MAX, MAXU: return COMPARE;
            default: return NONE;
        endcase
    endfunction

    function automatic bmu_decoded_t ref_decode(input logic [`BMU_INSTR_W-1:0] w);
        bmu_decoded_t d;
        bmu_opcode_e  opc;
        logic         shamt_form;
        logic         reads_rs2;
        logic [9:0]   key;
        d          = '0;
        opc        = NOP;
        shamt_form = 1'b0;
        reads_rs2  = 1'b0;
        key        = {w[14:12], w[31:25]};
        if (w[1:0] == 2'b11 && w[6:2] == 5'b00100) begin
            case (key)
                10'b001_0010100: opc = BSET;
                10'b001_0100100: opc = BCLR;
                10'b001_0110100: opc = BINV;
                10'b101_0100100: opc = BEXT;
                10'b101_0110000: opc = ROR;
                10'b101_0110100: opc = (w[24:20] == 5'b11000) ? REV8 : NOP;
                10'b101_0010100: opc = (w[24:20] == 5'b00111) ? ORCB : NOP;
                10'b001_0110000: begin
                    case (w[24:20])
                        5'd0: opc = CLZ;
                        5'd1: opc = CTZ;
                        5'd2: opc = CPOP;
                        5'd4: opc = SEXTB;
                        5'd5: opc = SEXTH;
                        default: opc = NOP;
                    endcase
                end
                default: opc = NOP;
            endcase
            // In OP-IMM only the bit and rotate forms carry a shift amount
            shamt_form = (class_of(opc) == LOGICOP) || (class_of(opc) == ROTATE);
        end else if (w[1:0] == 2'b11 && w[6:2] == 5'b01100) begin
            case (key)
                10'b001_0010100: opc = BSET;
                10'b001_0100100: opc = BCLR;
                10'b001_0110100: opc = BINV;
                10'b001_0110000: opc = ROL;
                10'b010_0010000: opc = SH1ADD;
                10'b100_0010000: opc = SH2ADD;
                10'b100_0000101: opc = MIN;
                10'b100_0100000: opc = XNOR;
                10'b100_0000100: opc = (w[24:20] == 5'd0) ? ZEXTH : NOP;
                10'b101_0000101: opc = MINU;
                10'b101_0100100: opc = BEXT;
                10'b101_0110000: opc = ROR;
                10'b110_0000101: opc = MAX;
                10'b110_0010000: opc = SH3ADD;
                10'b110_0100000: opc = ORN;
                10'b111_0100000: opc = ANDN;
                10'b111_0000101: opc = MAXU;
                default: opc = NOP;
            endcase
            reads_rs2 = (opc != ZEXTH);
        end
        if (opc == NOP) begin
            d.illegal = 1'b1;
        end else begin
            d.uop.op_type = class_of(opc);
            d.uop.opcode  = opc;
            d.rs1         = w[19:15];
            d.rs2         = reads_rs2 ? w[24:20] : 5'd0;
            d.rd          = w[11:7];
            d.imm         = shamt_form ? {{(`BMU_XLEN-5){1'b0}}, w[24:20]} : '0;
            d.imm_valid   = shamt_form;
        end
        return d;
    endfunction

    // ------------------------------
    // Checks
    // ------------------------------

    task automatic report_fail(input string msg);
        $display("FAIL @ %0t: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_uop(input bmu_uop_t got, input bmu_uop_t exp, input string ctx);
        if (got !== exp) begin
            report_fail($sformatf("%s uop class %0d op %0d, expected class %0d op %0d",
                                  ctx, got.op_type, got.opcode, exp.op_type, exp.opcode));
        end
    endtask

    task automatic check_regs(input bmu_decoded_t got, input bmu_decoded_t exp, input string ctx);
        if ({got.rs1, got.rs2, got.rd} !== {exp.rs1, exp.rs2, exp.rd}) begin
            report_fail($sformatf("%s rs1/rs2/rd %0d/%0d/%0d, expected %0d/%0d/%0d", ctx,
                                  got.rs1, got.rs2, got.rd, exp.rs1, exp.rs2, exp.rd));
        end
    endtask

    task automatic check_imm(input bmu_decoded_t got, input bmu_decoded_t exp, input string ctx);
        if (got.imm !== exp.imm || got.imm_valid !== exp.imm_valid) begin
            report_fail($sformatf("%s imm %h valid %b, expected %h valid %b", ctx,
                                  got.imm, got.imm_valid, exp.imm, exp.imm_valid));
        end
    endtask

    task automatic check_illegal(input logic got, input logic exp, input string ctx);
        if (got !== exp) begin
            report_fail($sformatf("%s illegal %b, expected %b", ctx, got, exp));
        end
    endtask

    task automatic compare_packet(input bmu_decoded_t got, input bmu_decoded_t exp,
                                  input string ctx);
        check_illegal(got.illegal, exp.illegal, ctx);
        check_uop(got.uop, exp.uop, ctx);
        check_regs(got, exp, ctx);
        check_imm(got, exp, ctx);
    endtask

    // ------------------------------
    // Stimulus helpers
    // ------------------------------

    task automatic advance_cycle();
        @(posedge clk);
        #1;
        dec_ready = (($urandom % 100) < 70);
    endtask

    function automatic logic [4:0] rand_reg();
        return $urandom_range(31, 0);
    endfunction

    function automatic logic [`BMU_INSTR_W-1:0] make_word(input logic [6:0] f7,
            input logic [4:0] rs2, input logic [2:0] f3, input logic [4:0] major);
        return {f7, rs2, rand_reg(), f3, rand_reg(), major, 2'b11};
    endfunction

    task automatic send_word(input logic [`BMU_INSTR_W-1:0] word);
        logic taken;
        instr_valid = 1'b1;
        instr       = word;
        taken       = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = instr_ready;
            advance_cycle();
        end
        instr_valid = 1'b0;
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------

    initial begin
        int unsigned             rng_seed;
        logic [`BMU_INSTR_W-1:0] word;
        logic [3:0]              pick;
        rng_seed    = 32'h6a26;
        instr_valid = 1'b0;
        instr       = '0;
        dec_ready   = 1'b0;
        void'($urandom(rng_seed));
        do begin
            advance_cycle();
        end while (rst !== 1'b0);

        // Register forms, ZEXT.H with rs2 zero
        send_word(make_word(7'b0010100, rand_reg(), 3'b001, OP));
        send_word(make_word(7'b0100100, rand_reg(), 3'b001, OP));
        send_word(make_word(7'b0110100, rand_reg(), 3'b001, OP));
        send_word(make_word(7'b0110000, rand_reg(), 3'b001, OP));
        send_word(make_word(7'b0010000, rand_reg(), 3'b010, OP));
        send_word(make_word(7'b0010000, rand_reg(), 3'b100, OP));
        send_word(make_word(7'b0000101, rand_reg(), 3'b100, OP));
        send_word(make_word(7'b0000100, 5'd0, 3'b100, OP));
        send_word(make_word(7'b0000101, rand_reg(), 3'b101, OP));
        send_word(make_word(7'b0100100, rand_reg(), 3'b101, OP));
        send_word(make_word(7'b0110000, rand_reg(), 3'b101, OP));
        send_word(make_word(7'b0000101, rand_reg(), 3'b110, OP));
        send_word(make_word(7'b0010000, rand_reg(), 3'b110, OP));
        send_word(make_word(7'b0000101, rand_reg(), 3'b111, OP));

        // Shift-amount forms and the unary group over every rs2 value
        for (int s = 0; s < 32; s++) begin
            send_word(make_word(7'b0010100, s[4:0], 3'b001, OP_IMM));
            send_word(make_word(7'b0100100, s[4:0], 3'b001, OP_IMM));
            send_word(make_word(7'b0110100, s[4:0], 3'b001, OP_IMM));
            send_word(make_word(7'b0100100, s[4:0], 3'b101, OP_IMM));
            send_word(make_word(7'b0110000, s[4:0], 3'b101, OP_IMM));
            send_word(make_word(7'b0110000, s[4:0], 3'b001, OP_IMM));
        end
        send_word(make_word(7'b0110100, 5'b11000, 3'b101, OP_IMM));
        send_word(make_word(7'b0010100, 5'b00111, 3'b101, OP_IMM));
        send_word(make_word(7'b0110100, 5'b11001, 3'b101, OP_IMM));
        send_word(make_word(7'b0010100, 5'b00110, 3'b101, OP_IMM));

        // Every funct3 against one funct7, plus wrong funct7, opcode and low bits
        for (int f = 0; f < 8; f++) begin
            send_word(make_word(7'b0100000, rand_reg(), f[2:0], OP));
            send_word(make_word(7'b0100100, rand_reg(), f[2:0], OP_IMM));
        end
        send_word(make_word(7'b0000001, rand_reg(), 3'b001, OP));
        send_word(make_word(7'b0000000, rand_reg(), 3'b001, OP_IMM));
        send_word(make_word(7'b0000100, 5'd3, 3'b100, OP));
        send_word(make_word(7'b0010100, rand_reg(), 3'b001, 5'b01101));
        for (int l = 0; l < 3; l++) begin
            word      = make_word(7'b0010100, rand_reg(), 3'b001, OP);
            word[1:0] = l[1:0];
            send_word(word);
        end

        // Random words, mostly on the two major opcodes with funct7 values in use
        repeat (RANDOM_WORDS) begin
            word = $urandom;
            pick = $urandom_range(15, 0);
            if ($urandom_range(9, 0) < 8) begin
                word[6:2]   = pick[0] ? OP : OP_IMM;
                word[31:25] = {1'b0, pick[3], pick[2], 1'b0, pick[1], 1'b0, word[25]};
            end
            if ($urandom_range(9, 0) < 9) begin
                word[1:0] = 2'b11;
            end
            send_word(word);
        end

        while (exp_q.size() != 0 || dec_valid) begin
            advance_cycle();
        end
        $display("Test passed");
        $finish;
    end

    // ------------------------------
    // Scoreboard
    // ------------------------------

    // Sampled at the falling edge, where inputs and registered outputs are settled
    always @(negedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d decodes outstanding",
                     cycle_count, exp_q.size());
            $display("Test failed");
            $fatal(1, "simulation timed out");
        end
        if (rst || reset_tail) begin
            if (dec_valid !== 1'b0 || instr_ready !== 1'b1) begin
                report_fail($sformatf("around reset dec_valid_o %b instr_ready_o %b",
                                      dec_valid, instr_ready));
            end
        end
        reset_tail = rst;
        if (!rst) begin
            // The output register holds one item so the queue mirrors its occupancy
            if (dec_valid !== (exp_q.size() != 0)) begin
                report_fail($sformatf("dec_valid_o %b with %0d decodes outstanding",
                                      dec_valid, exp_q.size()));
            end
            if (instr_ready !== (exp_q.size() == 0 || dec_ready)) begin
                report_fail($sformatf("instr_ready_o %b with %0d outstanding, dec_ready_i %b",
                                      instr_ready, exp_q.size(), dec_ready));
            end
            if (holding) begin
                if (dec_valid !== 1'b1) begin
                    report_fail("dec_valid_o dropped before the output was taken");
                end
                compare_packet(dec, held_dec, "held output");
            end
            holding  = dec_valid && !dec_ready;
            held_dec = dec;
            if (dec_valid && dec_ready) begin
                if (exp_q.size() == 0) begin
                    report_fail("output transfer with no instruction outstanding");
                end else begin
                    compare_packet(dec, exp_q.pop_front(),
                                   $sformatf("instr %08h", word_q.pop_front()));
                end
            end
            if (instr_valid && instr_ready) begin
                exp_q.push_back(ref_decode(instr));
                word_q.push_back(instr);
            end
        end
    end

endmodule

// File: flist.f
+incdir+verilog
verilog/bmu_decode_pkg.sv
verilog/bmu_imm_decoder.sv
verilog/bmu_reg_decoder.sv
verilog/bmu_decode_stage.sv
verilog/bmu_decoder_top.sv
testbench/tb_clock_gen.sv
testbench/tb_bmu_decoder.sv

// File: Bender.yml
package:
  name: bmu_decoder

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/bmu_decode_pkg.sv
      - verilog/bmu_imm_decoder.sv
      - verilog/bmu_reg_decoder.sv
      - verilog/bmu_decode_stage.sv
      - verilog/bmu_decoder_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_bmu_decoder.sv
